/* design/alu_pkg.sv */
package alu_pkg;

   localparam int data_width = 32;
   // one extra bit so the compare can read a sign
   localparam int adder_width = data_width + 1;
   localparam int reg_addr_width = 5;
   localparam int reg_count = 1 << reg_addr_width;
   localparam int shamt_width = $clog2(data_width);
   localparam int alu_op_width = 10;

   // bit positions inside the one-hot operation vector
   localparam int bit_add = 0;
   localparam int bit_sub = 1;
   localparam int bit_xor = 2;
   localparam int bit_sll = 3;
   localparam int bit_srl = 4;
   localparam int bit_sra = 5;
   localparam int bit_or = 6;
   localparam int bit_and = 7;
   localparam int bit_slt = 8;
   localparam int bit_sltu = 9;

   typedef enum logic [6:0] {
      op_reg = 7'b0110011,
      op_imm = 7'b0010011
   } opcode_e;

   typedef enum logic [2:0] {
      f3_add_sub = 3'b000,
      f3_sll = 3'b001,
      f3_slt = 3'b010,
      f3_sltu = 3'b011,
      f3_xor = 3'b100,
      f3_srl_sra = 3'b101,
      f3_or = 3'b110,
      f3_and = 3'b111
   } funct3_e;

   typedef enum logic [alu_op_width-1:0] {
      alu_nop = '0,
      alu_add = alu_op_width'(1 << bit_add),
      alu_sub = alu_op_width'(1 << bit_sub),
      alu_xor = alu_op_width'(1 << bit_xor),
      alu_sll = alu_op_width'(1 << bit_sll),
      alu_srl = alu_op_width'(1 << bit_srl),
      alu_sra = alu_op_width'(1 << bit_sra),
      alu_or = alu_op_width'(1 << bit_or),
      alu_and = alu_op_width'(1 << bit_and),
      alu_slt = alu_op_width'(1 << bit_slt),
      alu_sltu = alu_op_width'(1 << bit_sltu)
   } alu_op_e;

endpackage

/* design/alu_if.sv */
`timescale 1ns/10ps

interface alu_if import alu_pkg::*; ();

   logic [data_width-1:0] src_1;
   logic [data_width-1:0] src_2;
   alu_op_e operation;
   logic [data_width-1:0] result;
   logic zero;

   // pipeline side
   modport pipe (
      output src_1,
      output src_2,
      output operation,
      input result,
      input zero
   );

   modport alu (
      input src_1,
      input src_2,
      input operation,
      output result,
      output zero
   );

endinterface

/* design/inst_decode.sv */
`timescale 1ns/10ps

module inst_decode import alu_pkg::*; (
   input logic [data_width-1:0] instr,
   output logic [reg_addr_width-1:0] rs1,
   output logic [reg_addr_width-1:0] rs2,
   output logic [reg_addr_width-1:0] rd,
   output logic [data_width-1:0] imm,
   output logic use_imm,
   output alu_op_e operation
);

   opcode_e opcode;
   funct3_e funct3;
   logic alt_imm;

   // alt picks sub over add and sra over srl
   function automatic alu_op_e map_funct3(funct3_e f3, logic alt);
      alu_op_e op;
      case (f3)
         f3_add_sub: op = alt ? alu_sub : alu_add;
         f3_sll: op = alu_sll;
         f3_slt: op = alu_slt;
         f3_sltu: op = alu_sltu;
         f3_xor: op = alu_xor;
         f3_srl_sra: op = alt ? alu_sra : alu_srl;
         f3_or: op = alu_or;
         f3_and: op = alu_and;
         default: op = alu_nop;
      endcase
      return op;
   endfunction

   assign opcode = opcode_e'(instr[6:0]);
   assign funct3 = funct3_e'(instr[14:12]);
   assign rd = instr[11:7];
   assign rs1 = instr[19:15];
   assign rs2 = instr[24:20];
   // shift-immediates keep their amount in the low 5 bits of this field
   assign imm = {{(data_width-12){instr[31]}}, instr[31:20]};

   // no subi exists so bit 30 only matters for srai
   assign alt_imm = instr[30] && (funct3 == f3_srl_sra);

   always_comb begin
      case (opcode)
         op_reg: begin
            use_imm = 1'b0;
            operation = map_funct3(funct3, instr[30]);
         end
         op_imm: begin
            use_imm = 1'b1;
            operation = map_funct3(funct3, alt_imm);
         end
         default: begin
            use_imm = 1'b0;
            operation = alu_nop;
         end
      endcase
   end

endmodule

/* design/reg_file.sv */
`timescale 1ns/10ps

module reg_file import alu_pkg::*; (
   input logic clk,
   input logic rst,
   input logic [reg_addr_width-1:0] raddr_1,
   input logic [reg_addr_width-1:0] raddr_2,
   output logic [data_width-1:0] rdata_1,
   output logic [data_width-1:0] rdata_2,
   input logic we,
   input logic [reg_addr_width-1:0] waddr,
   input logic [data_width-1:0] wdata
);

   // x0 has no storage
   logic [data_width-1:0] regs [1:reg_count-1];

   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 1; i < reg_count; i++) begin
            regs[i] <= '0;
         end
      end else if (we && waddr != '0) begin
         regs[waddr] <= wdata;
      end
   end

   // no write bypass since the pipeline forwards the one close hazard
   assign rdata_1 = (raddr_1 == '0) ? '0 : regs[raddr_1];
   assign rdata_2 = (raddr_2 == '0) ? '0 : regs[raddr_2];

endmodule

/* design/alu.sv */
`timescale 1ns/10ps

module alu import alu_pkg::*; (
   alu_if.alu bus
);

   logic op_add;
   logic op_sub;
   logic op_xor;
   logic op_sll;
   logic op_srl;
   logic op_sra;
   logic op_or;
   logic op_and;
   logic op_slt;
   logic op_sltu;
   logic op_addsub;
   logic op_cmp;
   logic op_shift;
   logic shift_right;
   logic adder_sub;
   logic adder_en;

   logic [adder_width-1:0] adder_op_1;
   logic [adder_width-1:0] adder_op_2;
   logic [adder_width-1:0] adder_in_1;
   logic [adder_width-1:0] adder_in_2;
   logic [adder_width-1:0] adder_res;
   logic cmp_lt;
   logic [data_width-1:0] slt_res;

   logic [shamt_width-1:0] shamt;
   logic [data_width-1:0] shifter_in;
   logic [data_width-1:0] shifter_res;
   logic [data_width-1:0] srl_res;
   logic [data_width-1:0] sra_mask;
   logic [data_width-1:0] sra_res;

   function automatic logic [data_width-1:0] bit_reverse(logic [data_width-1:0] value);
      logic [data_width-1:0] rev;
      for (int i = 0; i < data_width; i++) begin
         rev[i] = value[data_width-1-i];
      end
      return rev;
   endfunction

   assign op_add = bus.operation[bit_add];
   assign op_sub = bus.operation[bit_sub];
   assign op_xor = bus.operation[bit_xor];
   assign op_sll = bus.operation[bit_sll];
   assign op_srl = bus.operation[bit_srl];
   assign op_sra = bus.operation[bit_sra];
   assign op_or = bus.operation[bit_or];
   assign op_and = bus.operation[bit_and];
   assign op_slt = bus.operation[bit_slt];
   assign op_sltu = bus.operation[bit_sltu];

   assign op_addsub = op_add | op_sub;
   assign op_cmp = op_slt | op_sltu;
   assign adder_sub = op_sub | op_cmp;
   assign adder_en = op_addsub | op_cmp;

   // signed compare extends the sign, unsigned extends zero
   assign adder_op_1 = {~op_sltu & bus.src_1[data_width-1], bus.src_1};
   assign adder_op_2 = {~op_sltu & bus.src_2[data_width-1], bus.src_2};
   assign adder_in_1 = {adder_width{adder_en}} & adder_op_1;
   assign adder_in_2 = {adder_width{adder_en}} & (adder_sub ? ~adder_op_2 : adder_op_2);
   assign adder_res = adder_in_1 + adder_in_2 + adder_width'(adder_sub);

   // less than when the 33-bit difference is negative
   assign cmp_lt = op_cmp & adder_res[adder_width-1];
   assign slt_res = {{(data_width-1){1'b0}}, cmp_lt};

   assign shift_right = op_srl | op_sra;
   assign op_shift = op_sll | shift_right;
   assign shamt = {shamt_width{op_shift}} & bus.src_2[shamt_width-1:0];

   // right shifts run through the left shifter on reversed bits
   assign shifter_in = {data_width{op_shift}} &
                       (shift_right ? bit_reverse(bus.src_1) : bus.src_1);
   assign shifter_res = shifter_in << shamt;
   assign srl_res = bit_reverse(shifter_res);

   assign sra_mask = {data_width{1'b1}} >> shamt;
   assign sra_res = (srl_res & sra_mask) |
                    ({data_width{bus.src_1[data_width-1]}} & ~sra_mask);

   assign bus.result = ({data_width{op_addsub}} & adder_res[data_width-1:0]) |
                       ({data_width{op_xor}} & (bus.src_1 ^ bus.src_2)) |
                       ({data_width{op_sll}} & shifter_res) |
                       ({data_width{op_srl}} & srl_res) |
                       ({data_width{op_sra}} & sra_res) |
                       ({data_width{op_or}} & (bus.src_1 | bus.src_2)) |
                       ({data_width{op_and}} & (bus.src_1 & bus.src_2)) |
                       ({data_width{op_cmp}} & slt_res);

   assign bus.zero = op_sub & ~(|adder_res[data_width-1:0]);

endmodule

/* design/ex_pipeline.sv */
`timescale 1ns/10ps

module ex_pipeline import alu_pkg::*; (
   input logic clk,
   input logic rst,
   input logic instr_valid,
   input logic [reg_addr_width-1:0] rs1,
   input logic [reg_addr_width-1:0] rs2,
   input logic [reg_addr_width-1:0] rd,
   input logic [data_width-1:0] imm,
   input logic use_imm,
   input alu_op_e operation,
   input logic [data_width-1:0] rdata_1,
   input logic [data_width-1:0] rdata_2,
   output logic we,
   output logic [reg_addr_width-1:0] waddr,
   output logic [data_width-1:0] wdata,
   alu_if.pipe alu_bus,
   output logic wb_valid,
   output logic [reg_addr_width-1:0] wb_rd,
   output logic [data_width-1:0] wb_data,
   output logic wb_zero
);

   logic accept;
   logic fwd_1;
   logic fwd_2;
   logic [data_width-1:0] op_src_1;
   logic [data_width-1:0] op_src_2;

   logic ex_valid;
   alu_op_e ex_op;
   logic [reg_addr_width-1:0] ex_rd;
   logic [data_width-1:0] ex_src_1;
   logic [data_width-1:0] ex_src_2;

   // non-alu opcodes and writes to x0 become bubbles
   assign accept = instr_valid && (operation != alu_nop) && (rd != '0);

   // the instruction just ahead has not reached the register file yet
   assign fwd_1 = ex_valid && (ex_rd == rs1);
   assign fwd_2 = ex_valid && (ex_rd == rs2);
   assign op_src_1 = fwd_1 ? alu_bus.result : rdata_1;
   assign op_src_2 = use_imm ? imm : (fwd_2 ? alu_bus.result : rdata_2);

   always_ff @(posedge clk) begin
      if (rst) begin
         ex_valid <= 1'b0;
         ex_op <= alu_nop;
      end else begin
         ex_valid <= accept;
         ex_op <= accept ? operation : alu_nop;
      end
   end

   always_ff @(posedge clk) begin
      ex_rd <= rd;
      ex_src_1 <= op_src_1;
      ex_src_2 <= op_src_2;
   end

   assign alu_bus.src_1 = ex_src_1;
   assign alu_bus.src_2 = ex_src_2;
   assign alu_bus.operation = ex_op;

   // register file takes the result on the same edge as the wb stage
   assign we = ex_valid;
   assign waddr = ex_rd;
   assign wdata = alu_bus.result;

   always_ff @(posedge clk) begin
      if (rst) begin
         wb_valid <= 1'b0;
         wb_zero <= 1'b0;
      end else begin
         wb_valid <= ex_valid;
         // a bubble carries alu_nop, so zero stays low
         wb_zero <= alu_bus.zero;
      end
   end

   always_ff @(posedge clk) begin
      wb_rd <= ex_rd;
      wb_data <= alu_bus.result;
   end

endmodule

/* design/rv_alu_top.sv */
`timescale 1ns/10ps

module rv_alu_top import alu_pkg::*; (
   input logic clk,
   input logic rst,
   input logic instr_valid,
   input logic [data_width-1:0] instr,
   output logic wb_valid,
   output logic [reg_addr_width-1:0] wb_rd,
   output logic [data_width-1:0] wb_data,
   output logic wb_zero
);

   logic [reg_addr_width-1:0] rs1;
   logic [reg_addr_width-1:0] rs2;
   logic [reg_addr_width-1:0] rd;
   logic [data_width-1:0] imm;
   logic use_imm;
   alu_op_e operation;
   logic [data_width-1:0] rdata_1;
   logic [data_width-1:0] rdata_2;
   logic we;
   logic [reg_addr_width-1:0] waddr;
   logic [data_width-1:0] wdata;

   alu_if alu_bus_i ();

   inst_decode decode_i (
      .instr(instr),
      .rs1(rs1),
      .rs2(rs2),
      .rd(rd),
      .imm(imm),
      .use_imm(use_imm),
      .operation(operation)
   );

   reg_file reg_file_i (
      .clk(clk),
      .rst(rst),
      .raddr_1(rs1),
      .raddr_2(rs2),
      .rdata_1(rdata_1),
      .rdata_2(rdata_2),
      .we(we),
      .waddr(waddr),
      .wdata(wdata)
   );

   ex_pipeline pipe_i (
      .clk(clk),
      .rst(rst),
      .instr_valid(instr_valid),
      .rs1(rs1),
      .rs2(rs2),
      .rd(rd),
      .imm(imm),
      .use_imm(use_imm),
      .operation(operation),
      .rdata_1(rdata_1),
      .rdata_2(rdata_2),
      .we(we),
      .waddr(waddr),
      .wdata(wdata),
      .alu_bus(alu_bus_i),
      .wb_valid(wb_valid),
      .wb_rd(wb_rd),
      .wb_data(wb_data),
      .wb_zero(wb_zero)
   );

   alu alu_i (
      .bus(alu_bus_i)
   );

endmodule

/* test/rv_alu_props.sv */
`timescale 1ns/10ps

module rv_alu_props import alu_pkg::*; (
   input logic clk,
   input logic rst,
   input logic ex_valid,
   input logic wb_valid,
   input logic we,
   input logic [reg_addr_width-1:0] waddr,
   input logic [data_width-1:0] wb_data,
   input logic wb_zero
);

   wb_follows_ex: assert property (@(posedge clk) disable iff (rst)
      ex_valid |=> wb_valid)
      else $error("wb_valid missing one cycle after ex_valid");

   no_wb_without_ex: assert property (@(posedge clk) disable iff (rst)
      !ex_valid |=> !wb_valid)
      else $error("wb_valid raised without ex_valid in the cycle before");

   // x0 never takes a write
   no_x0_write: assert property (@(posedge clk) disable iff (rst)
      we |-> waddr != '0)
      else $error("register file write enabled for x0");

   zero_means_zero: assert property (@(posedge clk) disable iff (rst)
      wb_zero |-> wb_data == '0)
      else $error("wb_zero set with nonzero wb_data");

   quiet_after_reset: assert property (@(posedge clk)
      rst |=> !wb_valid && !ex_valid && !we && !wb_zero)
      else $error("output valid in the cycle after reset");

endmodule

bind ex_pipeline rv_alu_props props_i (
   .clk(clk),
   .rst(rst),
   .ex_valid(ex_valid),
   .wb_valid(wb_valid),
   .we(we),
   .waddr(waddr),
   .wb_data(wb_data),
   .wb_zero(wb_zero)
);

/* test/rv_alu_tb.sv */
`timescale 1ns/10ps

module rv_alu_tb import alu_pkg::*; ();

   localparam int max_entries = 128;
   localparam int random_count = 60;

   logic clk;
   logic rst;
   logic instr_valid;
   logic [data_width-1:0] instr;
   logic wb_valid;
   logic [reg_addr_width-1:0] wb_rd;
   logic [data_width-1:0] wb_data;
   logic wb_zero;

   // one row per instruction with the table rows ahead of the random ones
   string names [max_entries];
   logic [data_width-1:0] instrs [max_entries];
   logic exp_valid [max_entries];
   logic [reg_addr_width-1:0] exp_rd [max_entries];
   logic [data_width-1:0] exp_data [max_entries];
   logic exp_zero [max_entries];
   int entry_count = 0;

   logic [data_width-1:0] model [reg_count];
   logic [31:0] lfsr_state = 32'd2;

   // row index travelling alongside the two DUT stages
   int idx_now = -1;
   int idx_d1 = -1;
   int idx_d2 = -1;
   int errors = 0;
   int checks = 0;
   int cycles = 0;
   int cycle_limit = 0;

   rv_alu_top dut_i (
      .clk(clk),
      .rst(rst),
      .instr_valid(instr_valid),
      .instr(instr),
      .wb_valid(wb_valid),
      .wb_rd(wb_rd),
      .wb_data(wb_data),
      .wb_zero(wb_zero)
   );

   always #10 clk = ~clk;

   function automatic logic [31:0] enc_r(logic [2:0] f3, logic alt, logic [4:0] rd,
                                         logic [4:0] rs1, logic [4:0] rs2);
      return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, op_reg};
   endfunction

   function automatic logic [31:0] enc_i(logic [2:0] f3, logic [4:0] rd, logic [4:0] rs1,
                                         logic [11:0] imm);
      return {imm, rs1, f3, rd, op_imm};
   endfunction

   // architectural result of an rv32i alu operation
   function automatic logic [31:0] ref_alu(logic [2:0] f3, logic alt, logic [31:0] a,
                                           logic [31:0] b);
      case (f3)
         f3_add_sub: return alt ? a - b : a + b;
         f3_sll: return a << b[4:0];
         f3_slt: return {31'b0, $signed(a) < $signed(b)};
         f3_sltu: return {31'b0, a < b};
         f3_xor: return a ^ b;
         f3_srl_sra: return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
         f3_or: return a | b;
         default: return a & b;
      endcase
   endfunction

   function automatic logic [31:0] lfsr_next(logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
   endfunction

   function automatic logic [31:0] rand_bits(int n);
      logic [31:0] val;
      val = '0;
      for (int i = 0; i < n; i++) begin
         val[i] = lfsr_state[0];
         lfsr_state = lfsr_next(lfsr_state);
      end
      return val;
   endfunction

   task automatic add_entry(string name, logic [31:0] word, logic v, logic [4:0] rd,
                            logic [31:0] data, logic zero);
      names[entry_count] = name;
      instrs[entry_count] = word;
      exp_valid[entry_count] = v;
      exp_rd[entry_count] = rd;
      exp_data[entry_count] = data;
      exp_zero[entry_count] = zero;
      if (v) begin
         model[rd] = data;
      end
      entry_count++;
   endtask

   task automatic build_table();
      add_entry("addi_x1", enc_i(f3_add_sub, 1, 0, 12'd5), 1, 1, 32'h5, 0);
      add_entry("addi_x2", enc_i(f3_add_sub, 2, 0, 12'hfff), 1, 2, 32'hffffffff, 0);
      add_entry("addi_x3", enc_i(f3_add_sub, 3, 0, 12'd5), 1, 3, 32'h5, 0);
      add_entry("add_wrap", enc_r(f3_add_sub, 0, 4, 2, 1), 1, 4, 32'h4, 0);
      add_entry("sub_zero", enc_r(f3_add_sub, 1, 5, 1, 3), 1, 5, 32'h0, 1);
      add_entry("sub_wrap", enc_r(f3_add_sub, 1, 6, 0, 1), 1, 6, 32'hfffffffb, 0);
      add_entry("add_zero", enc_r(f3_add_sub, 0, 7, 6, 3), 1, 7, 32'h0, 0);
      add_entry("addi_x8", enc_i(f3_add_sub, 8, 0, 12'h0f0), 1, 8, 32'hf0, 0);
      add_entry("addi_x9", enc_i(f3_add_sub, 9, 0, 12'h0cc), 1, 9, 32'hcc, 0);
      add_entry("xor", enc_r(f3_xor, 0, 10, 8, 9), 1, 10, 32'h3c, 0);
      add_entry("or", enc_r(f3_or, 0, 11, 8, 9), 1, 11, 32'hfc, 0);
      add_entry("and", enc_r(f3_and, 0, 12, 8, 9), 1, 12, 32'hc0, 0);
      add_entry("addi_x16", enc_i(f3_add_sub, 16, 0, 12'd1), 1, 16, 32'h1, 0);
      add_entry("addi_x17", enc_i(f3_add_sub, 17, 0, 12'd31), 1, 17, 32'h1f, 0);
      add_entry("addi_x18", enc_i(f3_add_sub, 18, 0, 12'hff0), 1, 18, 32'hfffffff0, 0);
      add_entry("sll_0", enc_r(f3_sll, 0, 19, 18, 0), 1, 19, 32'hfffffff0, 0);
      add_entry("sll_1", enc_r(f3_sll, 0, 19, 18, 16), 1, 19, 32'hffffffe0, 0);
      add_entry("sll_31", enc_r(f3_sll, 0, 19, 16, 17), 1, 19, 32'h80000000, 0);
      add_entry("srl_0", enc_r(f3_srl_sra, 0, 20, 18, 0), 1, 20, 32'hfffffff0, 0);
      add_entry("srl_1", enc_r(f3_srl_sra, 0, 20, 18, 16), 1, 20, 32'h7ffffff8, 0);
      add_entry("srl_31", enc_r(f3_srl_sra, 0, 20, 18, 17), 1, 20, 32'h1, 0);
      add_entry("sra_0", enc_r(f3_srl_sra, 1, 21, 18, 0), 1, 21, 32'hfffffff0, 0);
      add_entry("sra_1", enc_r(f3_srl_sra, 1, 21, 18, 16), 1, 21, 32'hfffffff8, 0);
      add_entry("sra_31", enc_r(f3_srl_sra, 1, 21, 18, 17), 1, 21, 32'hffffffff, 0);
      add_entry("slli_0", enc_i(f3_sll, 22, 18, 12'd0), 1, 22, 32'hfffffff0, 0);
      add_entry("slli_1", enc_i(f3_sll, 22, 1, 12'd1), 1, 22, 32'ha, 0);
      add_entry("slli_31", enc_i(f3_sll, 22, 16, 12'd31), 1, 22, 32'h80000000, 0);
      add_entry("srli_0", enc_i(f3_srl_sra, 22, 18, 12'd0), 1, 22, 32'hfffffff0, 0);
      add_entry("srli_1", enc_i(f3_srl_sra, 22, 18, 12'd1), 1, 22, 32'h7ffffff8, 0);
      add_entry("srli_31", enc_i(f3_srl_sra, 22, 18, 12'd31), 1, 22, 32'h1, 0);
      // bit 30 of the word sits at bit 10 of the immediate
      add_entry("srai_0", enc_i(f3_srl_sra, 23, 18, 12'h400), 1, 23, 32'hfffffff0, 0);
      add_entry("srai_1", enc_i(f3_srl_sra, 23, 18, 12'h401), 1, 23, 32'hfffffff8, 0);
      add_entry("srai_31", enc_i(f3_srl_sra, 23, 18, 12'h41f), 1, 23, 32'hffffffff, 0);
      add_entry("slt_signs", enc_r(f3_slt, 0, 24, 2, 1), 1, 24, 32'h1, 0);
      add_entry("sltu_signs", enc_r(f3_sltu, 0, 24, 2, 1), 1, 24, 32'h0, 0);
      add_entry("slti_signs", enc_i(f3_slt, 25, 1, 12'hfff), 1, 25, 32'h0, 0);
      add_entry("sltiu_signs", enc_i(f3_sltu, 25, 1, 12'hfff), 1, 25, 32'h1, 0);
      add_entry("fwd_load", enc_i(f3_add_sub, 26, 0, 12'd100), 1, 26, 32'h64, 0);
      add_entry("fwd_both", enc_r(f3_add_sub, 0, 26, 26, 26), 1, 26, 32'hc8, 0);
      add_entry("fwd_imm", enc_i(f3_add_sub, 26, 26, 12'd1), 1, 26, 32'hc9, 0);
      add_entry("fwd_sub", enc_r(f3_add_sub, 1, 27, 26, 26), 1, 27, 32'h0, 1);
      add_entry("rf_two_apart", enc_r(f3_add_sub, 0, 28, 26, 1), 1, 28, 32'hce, 0);
      add_entry("x0_write", enc_i(f3_add_sub, 0, 1, 12'd123), 0, 0, 32'h0, 0);
      // lw x1, 0(x0)
      add_entry("non_alu", 32'h00002083, 0, 1, 32'h0, 0);
      add_entry("x0_read", enc_r(f3_add_sub, 0, 29, 0, 0), 1, 29, 32'h0, 0);
   endtask

   task automatic build_random();
      logic form;
      logic alt;
      logic [2:0] f3;
      logic [4:0] rd;
      logic [4:0] rs1;
      logic [4:0] rs2;
      logic [11:0] imm;
      logic [31:0] word;
      logic [31:0] data;
      logic zero;
      for (int i = 0; i < random_count; i++) begin
         form = rand_bits(1);
         // only x0..x7 so that hazards come up often
         rd = 5'(rand_bits(3));
         rs1 = 5'(rand_bits(3));
         rs2 = 5'(rand_bits(3));
         f3 = 3'(rand_bits(3));
         alt = rand_bits(1) && (f3 == f3_add_sub || f3 == f3_srl_sra);
         imm = 12'(rand_bits(12));
         if (form) begin
            word = enc_i(f3_add_sub, rd, rs1, imm);
            data = model[rs1] + {{20{imm[11]}}, imm};
            zero = 1'b0;
         end else begin
            word = enc_r(f3, alt, rd, rs1, rs2);
            data = ref_alu(f3, alt, model[rs1], model[rs2]);
            zero = (f3 == f3_add_sub) && alt && (data == '0);
         end
         add_entry($sformatf("random_%0d", i), word, rd != 0, rd, data, zero);
      end
   endtask

   task automatic check_value(string name, string field, logic [31:0] expected,
                              logic [31:0] actual);
      checks++;
      if (expected !== actual) begin
         errors++;
         $display("ERR %s %s expected %h actual %h", name, field, expected, actual);
      end
   endtask

   always @(posedge clk) begin
      idx_d1 <= idx_now;
      idx_d2 <= idx_d1;
   end

   always @(negedge clk) begin
      if (!rst) begin
         if (idx_d2 < 0) begin
            check_value("idle", "wb_valid", 0, wb_valid);
         end else begin
            check_value(names[idx_d2], "wb_valid", exp_valid[idx_d2], wb_valid);
            if (exp_valid[idx_d2]) begin
               check_value(names[idx_d2], "wb_rd", exp_rd[idx_d2], wb_rd);
               check_value(names[idx_d2], "wb_data", exp_data[idx_d2], wb_data);
               check_value(names[idx_d2], "wb_zero", exp_zero[idx_d2], wb_zero);
            end
         end
      end
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= cycle_limit) begin
         $display("timeout after %0d cycles, the run did not finish", cycles);
         $display("Test FAILED");
         $finish;
      end
   end

   initial begin
      clk = 1'b0;
      rst = 1'b1;
      instr_valid = 1'b0;
      instr = '0;
      for (int r = 0; r < reg_count; r++) begin
         model[r] = '0;
      end
      build_table();
      build_random();
      cycle_limit = entry_count + 20;

      repeat (3) @(posedge clk);
      rst <= 1'b0;
      for (int i = 0; i < entry_count; i++) begin
         @(posedge clk);
         instr_valid <= 1'b1;
         instr <= instrs[i];
         idx_now <= i;
      end
      @(posedge clk);
      instr_valid <= 1'b0;
      instr <= '0;
      idx_now <= -1;
      repeat (4) @(posedge clk);

      $display("errors: %0d in %0d checks", errors, checks);
      if (errors == 0) begin
         $display("Test OK");
      end else begin
         $display("Test FAILED");
      end
      $finish;
   end

endmodule

/* compile.f */
design/alu_pkg.sv
design/alu_if.sv
design/inst_decode.sv
design/reg_file.sv
design/alu.sv
design/ex_pipeline.sv
design/rv_alu_top.sv
test/rv_alu_props.sv
test/rv_alu_tb.sv

/* Bender.yml */
package:
  name: rv_alu

sources:
  - design/alu_pkg.sv
  - design/alu_if.sv
  - design/inst_decode.sv
  - design/reg_file.sv
  - design/alu.sv
  - design/ex_pipeline.sv
  - design/rv_alu_top.sv
  - target: test
    files:
      - test/rv_alu_props.sv
      - test/rv_alu_tb.sv
